// File: Makefile
TOP   = pio_ingress_tb
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir $(BUILD) -o $(TOP)

run: compile
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
+incdir+hdl
hdl/pio_reg_pkg.sv
hdl/pio_stream_pkg.sv
hdl/ctrl_decoder.sv
hdl/word_to_byte_converter.sv
hdl/byte_fifo.sv
hdl/ingress_channel.sv
hdl/stream_merger.sv
hdl/pio_ingress_top.sv
verif/tb_clock_gen.sv
verif/pio_ingress_checker.sv
verif/pio_ingress_tb.sv

// File: hdl/byte_fifo.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`PIO_DATA_WIDTH-1:0] in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`PIO_DATA_WIDTH-1:0] out_data
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [`PIO_DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W:0]             count;
    logic                       push;
    logic                       pop;

    assign in_ready  = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap on their own at a power-of-two depth
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/ctrl_decoder.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module ctrl_decoder import pio_reg_pkg::*, pio_stream_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ctrl_wen,
    input  logic [`PIO_ADDR_WIDTH-1:0]   ctrl_waddr,
    input  logic                         ctrl_ren,
    input  logic [`PIO_ADDR_WIDTH-1:0]   ctrl_raddr,
    input  reg_word_t                    chan_rdata [`PIO_NUM_CHANNELS],
    output logic [`PIO_NUM_CHANNELS-1:0] chan_wen,
    output reg_index_e                   reg_waddr,
    output reg_index_e                   reg_raddr,
    output reg_word_t                    ctrl_rdata
);

    chan_id_t wchan;
    chan_id_t rchan;

    // address fields
    assign wchan     = ctrl_waddr[`PIO_CHAN_LSB +: $bits(chan_id_t)];
    assign rchan     = ctrl_raddr[`PIO_CHAN_LSB +: $bits(chan_id_t)];
    assign reg_waddr = reg_index_e'(ctrl_waddr[`PIO_REG_LSB +: $bits(reg_index_e)]);
    assign reg_raddr = reg_index_e'(ctrl_raddr[`PIO_REG_LSB +: $bits(reg_index_e)]);

    // one-hot write strobe per channel
    always_comb begin
        chan_wen = '0;
        if (ctrl_wen) begin
            chan_wen[wchan] = 1'b1;
        end
    end

    // read returns zero outside an active read
    assign ctrl_rdata = ctrl_ren ? chan_rdata[rchan] : '0;

endmodule

// File: hdl/ingress_channel.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module ingress_channel import pio_reg_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wen,
    input  reg_index_e                 waddr,
    input  reg_word_t                  wdata,
    input  reg_index_e                 raddr,
    output reg_word_t                  rdata,
    output logic                       stream_valid,
    output logic [`PIO_DATA_WIDTH-1:0] stream_data,
    output logic                       stream_empty,
    input  logic                       stream_ready
);

    // ADAPTER_CTRL fields
    logic       compact_mode;
    logic       rec_mode;
    // DATA_MODE fields
    byte_keep_t data_keep;
    logic       data_last;
    logic       data_null;

    reg_word_t  data_xfer_cnt;
    reg_word_t  null_in_cnt;
    reg_word_t  null_xfer_cnt;

    logic                       flush;
    logic                       word_valid;
    logic                       word_ready;
    logic                       conv_valid;
    logic                       conv_ready;
    logic [`PIO_DATA_WIDTH-1:0] conv_data;
    logic                       fifo_valid;
    logic [`PIO_DATA_WIDTH-1:0] fifo_data;
    logic                       null_valid;
    logic                       data_take;
    logic                       null_take;

    // DATA_RST flushes converter and buffer for one cycle
    assign flush      = wen && (waddr == REG_DATA_RST);
    assign word_valid = wen && (waddr == REG_DATA_IN);

    always_ff @(posedge clk) begin
        if (rst) begin
            compact_mode <= 1'b1;
            rec_mode     <= 1'b0;
        end else if (wen && (waddr == REG_ADAPTER_CTRL)) begin
            compact_mode <= wdata[0];
            rec_mode     <= wdata[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_keep <= '1;
            data_last <= 1'b0;
            data_null <= 1'b0;
        end else if (wen && (waddr == REG_DATA_MODE)) begin
            data_keep <= wdata[$bits(byte_keep_t)-1:0];
            data_last <= wdata[4];
            data_null <= wdata[31];
        end
    end

    word_to_byte_converter u_conv (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (word_valid),
        .in_ready  (word_ready),
        .in_data   (wdata),
        .in_keep   (data_keep),
        .out_valid (conv_valid),
        .out_ready (conv_ready),
        .out_data  (conv_data)
    );

    byte_fifo #(
        .FIFO_DEPTH (`PIO_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (conv_valid),
        .in_ready  (conv_ready),
        .in_data   (conv_data),
        .out_valid (fifo_valid),
        .out_ready (stream_ready),
        .out_data  (fifo_data)
    );

    // nulls only go out while the buffer is empty
    assign null_valid   = rec_mode || (null_in_cnt != '0);
    assign data_take    = fifo_valid && stream_ready;
    assign null_take    = null_valid && stream_ready && !fifo_valid;
    assign stream_valid = fifo_valid || null_valid;
    assign stream_empty = !fifo_valid;
    assign stream_data  = fifo_data;

    // a register write wins over the count event
    always_ff @(posedge clk) begin
        if (rst) begin
            data_xfer_cnt <= '0;
            null_in_cnt   <= '0;
            null_xfer_cnt <= '0;
        end else begin
            if (wen && (waddr == REG_DATA_XFER_CNT)) begin
                data_xfer_cnt <= wdata;
            end else if (data_take) begin
                data_xfer_cnt <= data_xfer_cnt + 32'd1;
            end
            if (wen && (waddr == REG_NULL_IN_CNT)) begin
                null_in_cnt <= wdata;
            end else if (null_take && (null_in_cnt != '0)) begin
                null_in_cnt <= null_in_cnt - 32'd1;
            end
            if (wen && (waddr == REG_NULL_XFER_CNT)) begin
                null_xfer_cnt <= wdata;
            end else if (null_take && rec_mode) begin
                null_xfer_cnt <= null_xfer_cnt + 32'd1;
            end
        end
    end

    // write-only slots fall to the default
    always_comb begin
        case (raddr)
            REG_ADAPTER_CTRL:  rdata = {30'd0, rec_mode, compact_mode};
            REG_DATA_MODE:     rdata = {data_null, 26'd0, data_last, data_keep};
            REG_DATA_READY:    rdata = {31'd0, word_ready};
            REG_DATA_XFER_CNT: rdata = data_xfer_cnt;
            REG_NULL_IN_CNT:   rdata = null_in_cnt;
            REG_NULL_XFER_CNT: rdata = null_xfer_cnt;
            default:           rdata = '0;
        endcase
    end

endmodule

// File: hdl/pio_defines.svh
`ifndef PIO_DEFINES_SVH
`define PIO_DEFINES_SVH

// channel count and width of the output byte stream
`define PIO_NUM_CHANNELS 4
`define PIO_DATA_WIDTH   8

// buffer entries per channel as a power of two
`define PIO_FIFO_DEPTH   16

// control bus address layout
`define PIO_ADDR_WIDTH   32
// channel field sits above the register field
`define PIO_CHAN_LSB     5
`define PIO_REG_LSB      2

`endif

// File: hdl/pio_ingress_top.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_ingress_top import pio_reg_pkg::*, pio_stream_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ctrl_wen,
    input  logic [`PIO_ADDR_WIDTH-1:0] ctrl_waddr,
    input  reg_word_t                  ctrl_wdata,
    input  logic                       ctrl_ren,
    input  logic [`PIO_ADDR_WIDTH-1:0] ctrl_raddr,
    output reg_word_t                  ctrl_rdata,
    output logic                       out_valid,
    output logic [`PIO_DATA_WIDTH-1:0] out_data,
    output logic                       out_empty,
    output chan_id_t                   out_chan,
    input  logic                       out_ready
);

    logic [`PIO_NUM_CHANNELS-1:0] chan_wen;
    reg_index_e                   reg_waddr;
    reg_index_e                   reg_raddr;
    reg_word_t                    chan_rdata [`PIO_NUM_CHANNELS];
    logic [`PIO_NUM_CHANNELS-1:0] stream_valid;
    logic [`PIO_DATA_WIDTH-1:0]   stream_data [`PIO_NUM_CHANNELS];
    logic [`PIO_NUM_CHANNELS-1:0] stream_empty;
    logic [`PIO_NUM_CHANNELS-1:0] stream_ready;

    ctrl_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .ctrl_wen   (ctrl_wen),
        .ctrl_waddr (ctrl_waddr),
        .ctrl_ren   (ctrl_ren),
        .ctrl_raddr (ctrl_raddr),
        .chan_rdata (chan_rdata),
        .chan_wen   (chan_wen),
        .reg_waddr  (reg_waddr),
        .reg_raddr  (reg_raddr),
        .ctrl_rdata (ctrl_rdata)
    );

    // write data and register fields are shared by all channels
    for (genvar i = 0; i < `PIO_NUM_CHANNELS; i++) begin : g_chan
        ingress_channel u_chan (
            .clk          (clk),
            .rst          (rst),
            .wen          (chan_wen[i]),
            .waddr        (reg_waddr),
            .wdata        (ctrl_wdata),
            .raddr        (reg_raddr),
            .rdata        (chan_rdata[i]),
            .stream_valid (stream_valid[i]),
            .stream_data  (stream_data[i]),
            .stream_empty (stream_empty[i]),
            .stream_ready (stream_ready[i])
        );
    end

    stream_merger u_merger (
        .clk          (clk),
        .rst          (rst),
        .stream_valid (stream_valid),
        .stream_data  (stream_data),
        .stream_empty (stream_empty),
        .stream_ready (stream_ready),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_empty    (out_empty),
        .out_chan     (out_chan),
        .out_ready    (out_ready)
    );

endmodule

// File: hdl/pio_reg_pkg.sv
package pio_reg_pkg;

`include "pio_defines.svh"

    // register slot inside one channel
    typedef enum logic [2:0] {
        REG_ADAPTER_CTRL  = 3'd0,
        REG_DATA_RST      = 3'd1,
        REG_DATA_MODE     = 3'd2,
        REG_DATA_READY    = 3'd3,
        REG_DATA_IN       = 3'd4,
        REG_DATA_XFER_CNT = 3'd5,
        REG_NULL_IN_CNT   = 3'd6,
        REG_NULL_XFER_CNT = 3'd7
    } reg_index_e;

    // one keep bit per byte lane of a control word
    typedef logic [32/`PIO_DATA_WIDTH-1:0] byte_keep_t;

    // full control bus word for registers and counters
    typedef logic [31:0] reg_word_t;

endpackage

// File: hdl/pio_stream_pkg.sv
package pio_stream_pkg;

`include "pio_defines.svh"

    // word to byte converter state
    typedef enum logic {
        CONV_IDLE,
        CONV_SHIFT
    } conv_state_e;

    // channel number carried with every output token
    typedef logic [$clog2(`PIO_NUM_CHANNELS)-1:0] chan_id_t;

endpackage

// File: hdl/stream_merger.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module stream_merger import pio_stream_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`PIO_NUM_CHANNELS-1:0] stream_valid,
    input  logic [`PIO_DATA_WIDTH-1:0]   stream_data [`PIO_NUM_CHANNELS],
    input  logic [`PIO_NUM_CHANNELS-1:0] stream_empty,
    output logic [`PIO_NUM_CHANNELS-1:0] stream_ready,
    output logic                         out_valid,
    output logic [`PIO_DATA_WIDTH-1:0]   out_data,
    output logic                         out_empty,
    output chan_id_t                     out_chan,
    input  logic                         out_ready
);

    localparam int NUM = `PIO_NUM_CHANNELS;

    chan_id_t rr_ptr;
    chan_id_t grant;
    logic     grant_found;

    // first valid channel at or after the pointer with wraparound
    always_comb begin
        int idx;
        idx         = 0;
        grant       = rr_ptr;
        grant_found = 1'b0;
        for (int k = NUM - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % NUM;
            if (stream_valid[idx]) begin
                grant       = chan_id_t'(idx);
                grant_found = 1'b1;
            end
        end
    end

    always_comb begin
        stream_ready = '0;
        if (grant_found && out_ready) begin
            stream_ready[grant] = 1'b1;
        end
    end

    assign out_valid = grant_found;
    assign out_data  = stream_data[grant];
    assign out_empty = stream_empty[grant];
    assign out_chan  = grant;

    // next scan starts one past the winner
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (grant_found && out_ready) begin
            rr_ptr <= chan_id_t'((int'(grant) + 1) % NUM);
        end
    end

endmodule

// File: hdl/word_to_byte_converter.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module word_to_byte_converter import pio_reg_pkg::*, pio_stream_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [31:0]                in_data,
    input  byte_keep_t                 in_keep,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`PIO_DATA_WIDTH-1:0] out_data
);

    conv_state_e state;
    logic [31:0] word_q;
    byte_keep_t  keep_q;
    byte_keep_t  keep_next;
    int          lane;

    // lowest remaining kept lane
    always_comb begin
        lane = 0;
        for (int i = $bits(byte_keep_t) - 1; i >= 0; i--) begin
            if (keep_q[i]) begin
                lane = i;
            end
        end
        keep_next       = keep_q;
        keep_next[lane] = 1'b0;
    end

    assign in_ready  = (state == CONV_IDLE);
    assign out_valid = (state == CONV_SHIFT);
    assign out_data  = word_q[lane*`PIO_DATA_WIDTH +: `PIO_DATA_WIDTH];

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            word_q <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state  <= CONV_IDLE;
            keep_q <= '0;
        end else if (state == CONV_IDLE) begin
            // empty keep mask emits nothing
            if (in_valid && (in_keep != '0)) begin
                state  <= CONV_SHIFT;
                keep_q <= in_keep;
            end
        end else if (out_ready) begin
            keep_q <= keep_next;
            if (keep_next == '0) begin
                state <= CONV_IDLE;
            end
        end
    end

endmodule

// File: verif/pio_ingress_checker.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_ingress_checker import pio_stream_pkg::*; #(
    parameter int CNT_W = $clog2(`PIO_FIFO_DEPTH) + 1
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               out_valid,
    input  logic                               out_ready,
    input  chan_id_t                           out_chan,
    input  logic [`PIO_NUM_CHANNELS-1:0]       stream_valid,
    input  logic [`PIO_NUM_CHANNELS-1:0]       conv_state,
    input  logic [`PIO_NUM_CHANNELS-1:0]       conv_in_valid,
    input  logic [`PIO_NUM_CHANNELS-1:0]       fifo_push,
    input  logic [`PIO_NUM_CHANNELS*CNT_W-1:0] fifo_count
);

    a_reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !out_valid)
        else $error("output valid while in reset");

    // grant may only move when the set of requesting channels changes
    a_chan_hold: assert property (@(posedge clk) disable iff (rst)
        $past(out_valid && !out_ready) && $stable(stream_valid) |-> $stable(out_chan))
        else $error("output channel changed under back-pressure");

    for (genvar i = 0; i < `PIO_NUM_CHANNELS; i++) begin : g_lane
        a_conv_start: assert property (@(posedge clk) disable iff (rst)
            (conv_state_e'(conv_state[i]) == CONV_IDLE) && !conv_in_valid[i]
            |=> conv_state_e'(conv_state[i]) == CONV_IDLE)
            else $error("converter %0d left idle without an input word", i);

        // a write into a full buffer would push the count past the depth
        a_fifo_room: assert property (@(posedge clk) disable iff (rst)
            fifo_push[i] |=> fifo_count[i*CNT_W +: CNT_W] <= CNT_W'(`PIO_FIFO_DEPTH))
            else $error("fifo %0d written while full", i);
    end

endmodule

bind pio_ingress_top pio_ingress_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_chan      (out_chan),
    .stream_valid  (stream_valid),
    .conv_state    ({g_chan[3].u_chan.u_conv.state, g_chan[2].u_chan.u_conv.state,
                     g_chan[1].u_chan.u_conv.state, g_chan[0].u_chan.u_conv.state}),
    .conv_in_valid ({g_chan[3].u_chan.word_valid, g_chan[2].u_chan.word_valid,
                     g_chan[1].u_chan.word_valid, g_chan[0].u_chan.word_valid}),
    .fifo_push     ({g_chan[3].u_chan.u_fifo.push, g_chan[2].u_chan.u_fifo.push,
                     g_chan[1].u_chan.u_fifo.push, g_chan[0].u_chan.u_fifo.push}),
    .fifo_count    ({g_chan[3].u_chan.u_fifo.count, g_chan[2].u_chan.u_fifo.count,
                     g_chan[1].u_chan.u_fifo.count, g_chan[0].u_chan.u_fifo.count})
);

// File: verif/pio_ingress_tb.sv
`timescale 1ns/1ps
`include "pio_defines.svh"

module pio_ingress_tb import pio_reg_pkg::*, pio_stream_pkg::*; ();

    typedef enum int {
        OP_WRITE,
        OP_READ,
        OP_BP,
        OP_DRAIN,
        OP_IDLE,
        OP_NULLS,
        OP_READ_NULLS,
        OP_READ_HELD
    } step_op_e;

    // out_ready modes
    localparam int BP_READY  = 0;
    localparam int BP_RANDOM = 1;
    localparam int BP_STALL  = 2;

    logic                       clk;
    logic                       rst;
    logic                       ctrl_wen;
    logic [`PIO_ADDR_WIDTH-1:0] ctrl_waddr;
    reg_word_t                  ctrl_wdata;
    logic                       ctrl_ren;
    logic [`PIO_ADDR_WIDTH-1:0] ctrl_raddr;
    reg_word_t                  ctrl_rdata;
    logic                       out_valid;
    logic [`PIO_DATA_WIDTH-1:0] out_data;
    logic                       out_empty;
    chan_id_t                   out_chan;
    logic                       out_ready;

    // stimulus table
    string       step_name [$];
    step_op_e    step_op [$];
    logic [31:0] step_addr [$];
    logic [31:0] step_data [$];
    logic [31:0] step_exp [$];

    // scoreboard state
    logic [`PIO_DATA_WIDTH-1:0] byte_q [`PIO_NUM_CHANNELS][$];
    byte_keep_t                 keep_model [`PIO_NUM_CHANNELS];
    int                         null_seen [`PIO_NUM_CHANNELS];
    // null count at the moment record mode was cleared
    int                         null_mark [`PIO_NUM_CHANNELS];
    logic [`PIO_DATA_WIDTH-1:0] exp_byte;

    int          errors = 0;
    int          checks = 0;
    int          bp_mode = BP_READY;
    logic [31:0] lfsr = 32'ha928;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    pio_ingress_top DUT (
        .clk        (clk),
        .rst        (rst),
        .ctrl_wen   (ctrl_wen),
        .ctrl_waddr (ctrl_waddr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_ren   (ctrl_ren),
        .ctrl_raddr (ctrl_raddr),
        .ctrl_rdata (ctrl_rdata),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_empty  (out_empty),
        .out_chan   (out_chan),
        .out_ready  (out_ready)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] reg_addr(input int ch, input reg_index_e r);
        logic [31:0] a;
        a = '0;
        a[`PIO_CHAN_LSB +: $bits(chan_id_t)] = chan_id_t'(ch);
        a[`PIO_REG_LSB +: $bits(reg_index_e)] = r;
        return a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic add_step(input string name, input step_op_e op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
        step_name.push_back(name);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_exp.push_back(exp);
    endtask

    task automatic build_table;
        string p;
        for (int c = 0; c < `PIO_NUM_CHANNELS; c++) begin
            p = $sformatf("reset ch%0d", c);
            add_step({p, " ADAPTER_CTRL"}, OP_READ, reg_addr(c, REG_ADAPTER_CTRL), 0, 1);
            add_step({p, " DATA_RST"}, OP_READ, reg_addr(c, REG_DATA_RST), 0, 0);
            add_step({p, " DATA_MODE"}, OP_READ, reg_addr(c, REG_DATA_MODE), 0, 32'hF);
            add_step({p, " DATA_READY"}, OP_READ, reg_addr(c, REG_DATA_READY), 0, 1);
            add_step({p, " DATA_IN"}, OP_READ, reg_addr(c, REG_DATA_IN), 0, 0);
            add_step({p, " DATA_XFER_CNT"}, OP_READ, reg_addr(c, REG_DATA_XFER_CNT), 0, 0);
            add_step({p, " NULL_IN_CNT"}, OP_READ, reg_addr(c, REG_NULL_IN_CNT), 0, 0);
            add_step({p, " NULL_XFER_CNT"}, OP_READ, reg_addr(c, REG_NULL_XFER_CNT), 0, 0);
        end
        // byte split with varied keep masks under random back-pressure
        add_step("bp random", OP_BP, 0, BP_RANDOM, 0);
        add_step("preset xfer ch0", OP_WRITE, reg_addr(0, REG_DATA_XFER_CNT), 100, 0);
        add_step("read xfer preset ch0", OP_READ, reg_addr(0, REG_DATA_XFER_CNT), 0, 100);
        add_step("word ch0 keep f", OP_WRITE, reg_addr(0, REG_DATA_IN), 32'h44332211, 0);
        add_step("mode ch1 keep a last", OP_WRITE, reg_addr(1, REG_DATA_MODE), 32'h1A, 0);
        add_step("read mode ch1", OP_READ, reg_addr(1, REG_DATA_MODE), 0, 32'h1A);
        add_step("word ch1 keep a", OP_WRITE, reg_addr(1, REG_DATA_IN), 32'hDDCCBBAA, 0);
        add_step("mode ch0 keep 5", OP_WRITE, reg_addr(0, REG_DATA_MODE), 32'h5, 0);
        add_step("word ch0 keep 5", OP_WRITE, reg_addr(0, REG_DATA_IN), 32'h88776655, 0);
        add_step("mode ch2 keep 0", OP_WRITE, reg_addr(2, REG_DATA_MODE), 32'h0, 0);
        add_step("word ch2 keep 0", OP_WRITE, reg_addr(2, REG_DATA_IN), 32'hFFEEDDCC, 0);
        add_step("mode ch1 keep 8 null", OP_WRITE, reg_addr(1, REG_DATA_MODE), 32'h80000008, 0);
        add_step("read mode ch1 null", OP_READ, reg_addr(1, REG_DATA_MODE), 0, 32'h80000008);
        add_step("word ch1 keep 8", OP_WRITE, reg_addr(1, REG_DATA_IN), 32'h04030201, 0);
        add_step("mode ch0 keep 6", OP_WRITE, reg_addr(0, REG_DATA_MODE), 32'h6, 0);
        add_step("word ch0 keep 6", OP_WRITE, reg_addr(0, REG_DATA_IN), 32'h0C0B0A09, 0);
        add_step("drain data", OP_DRAIN, 0, 0, 0);
        add_step("xfer count ch0", OP_READ, reg_addr(0, REG_DATA_XFER_CNT), 0, 108);
        add_step("xfer count ch1", OP_READ, reg_addr(1, REG_DATA_XFER_CNT), 0, 3);
        add_step("xfer count ch2", OP_READ, reg_addr(2, REG_DATA_XFER_CNT), 0, 0);
        // programmed null count
        add_step("null count ch2", OP_WRITE, reg_addr(2, REG_NULL_IN_CNT), 5, 0);
        add_step("drain nulls", OP_DRAIN, 0, 0, 0);
        add_step("nulls seen ch2", OP_NULLS, reg_addr(2, REG_NULL_IN_CNT), 0, 5);
        add_step("null count left ch2", OP_READ, reg_addr(2, REG_NULL_IN_CNT), 0, 0);
        add_step("null xfer ch2", OP_READ, reg_addr(2, REG_NULL_XFER_CNT), 0, 0);
        // record mode
        add_step("record on ch3", OP_WRITE, reg_addr(3, REG_ADAPTER_CTRL), 3, 0);
        add_step("read ctrl ch3", OP_READ, reg_addr(3, REG_ADAPTER_CTRL), 0, 3);
        add_step("record run", OP_IDLE, 0, 40, 0);
        add_step("record off ch3", OP_WRITE, reg_addr(3, REG_ADAPTER_CTRL), 1, 0);
        add_step("null xfer ch3", OP_READ_NULLS, reg_addr(3, REG_NULL_XFER_CNT), 0, 0);
        add_step("record stopped", OP_IDLE, 0, 20, 0);
        add_step("null xfer ch3 held", OP_READ_HELD, reg_addr(3, REG_NULL_XFER_CNT), 0, 0);
        // flush under a stalled output
        add_step("bp stall", OP_BP, 0, BP_STALL, 0);
        add_step("mode ch1 keep f", OP_WRITE, reg_addr(1, REG_DATA_MODE), 32'hF, 0);
        add_step("word ch1 first", OP_WRITE, reg_addr(1, REG_DATA_IN), 32'h11223344, 0);
        add_step("word ch1 second", OP_WRITE, reg_addr(1, REG_DATA_IN), 32'h55667788, 0);
        add_step("flush ch1", OP_WRITE, reg_addr(1, REG_DATA_RST), 0, 0);
        add_step("ready after flush", OP_READ, reg_addr(1, REG_DATA_READY), 0, 1);
        add_step("bp random again", OP_BP, 0, BP_RANDOM, 0);
        add_step("drain after flush", OP_DRAIN, 0, 0, 0);
        add_step("xfer after flush ch1", OP_READ, reg_addr(1, REG_DATA_XFER_CNT), 0, 3);
        add_step("mode ch1 keep 3", OP_WRITE, reg_addr(1, REG_DATA_MODE), 32'h3, 0);
        add_step("word ch1 keep 3", OP_WRITE, reg_addr(1, REG_DATA_IN), 32'h0000C3A5, 0);
        add_step("drain last", OP_DRAIN, 0, 0, 0);
        add_step("xfer final ch1", OP_READ, reg_addr(1, REG_DATA_XFER_CNT), 0, 5);
    endtask

    // polls DATA_READY until the converter is idle
    task automatic wait_data_ready(input int ch);
        logic ready;
        ready = 1'b0;
        while (!ready) begin
            @(negedge clk);
            ctrl_ren   = 1'b1;
            ctrl_raddr = reg_addr(ch, REG_DATA_READY);
            @(posedge clk);
            ready = ctrl_rdata[0];
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        int         ch;
        reg_index_e r;
        ch = int'(addr[`PIO_CHAN_LSB +: $bits(chan_id_t)]);
        r  = reg_index_e'(addr[`PIO_REG_LSB +: $bits(reg_index_e)]);
        if (r == REG_DATA_IN) begin
            wait_data_ready(ch);
        end
        @(negedge clk);
        ctrl_ren   = 1'b0;
        ctrl_wen   = 1'b1;
        ctrl_waddr = addr;
        ctrl_wdata = data;
        case (r)
            REG_DATA_MODE: keep_model[ch] = data[$bits(byte_keep_t)-1:0];
            REG_DATA_RST:  byte_q[ch].delete();
            REG_DATA_IN: begin
                // kept bytes leave lowest lane first
                for (int b = 0; b < $bits(byte_keep_t); b++) begin
                    if (keep_model[ch][b]) begin
                        byte_q[ch].push_back(data[b*`PIO_DATA_WIDTH +: `PIO_DATA_WIDTH]);
                    end
                end
            end
            default: ;
        endcase
        @(negedge clk);
        ctrl_wen = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] value);
        @(negedge clk);
        ctrl_ren   = 1'b1;
        ctrl_raddr = addr;
        @(posedge clk);
        value = ctrl_rdata;
        @(negedge clk);
        ctrl_ren = 1'b0;
    endtask

    task automatic wait_drain;
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = out_valid;
            for (int c = 0; c < `PIO_NUM_CHANNELS; c++) begin
                if (byte_q[c].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic run_step(input int i);
        logic [31:0] got;
        int          ch;
        ch = int'(step_addr[i][`PIO_CHAN_LSB +: $bits(chan_id_t)]);
        case (step_op[i])
            OP_WRITE: write_reg(step_addr[i], step_data[i]);
            OP_READ: begin
                read_reg(step_addr[i], got);
                check_value(step_name[i], step_exp[i], got);
            end
            OP_BP: begin
                @(posedge clk);
                bp_mode = int'(step_data[i]);
                @(negedge clk);
            end
            OP_DRAIN: wait_drain();
            OP_IDLE:  repeat (int'(step_data[i])) @(negedge clk);
            OP_NULLS: check_value(step_name[i], step_exp[i], null_seen[ch]);
            OP_READ_NULLS: begin
                read_reg(step_addr[i], got);
                check_value(step_name[i], null_seen[ch], got);
                if (null_seen[ch] == 0) begin
                    errors++;
                    $display("no null tokens arrived from channel %0d in record mode", ch);
                end
                null_mark[ch] = null_seen[ch];
            end
            OP_READ_HELD: begin
                read_reg(step_addr[i], got);
                check_value(step_name[i], null_mark[ch], got);
                check_value({step_name[i], " nulls"}, null_mark[ch], null_seen[ch]);
            end
            default: ;
        endcase
    endtask

    always @(negedge clk) begin
        case (bp_mode)
            BP_RANDOM: begin
                lfsr      = lfsr_next(lfsr);
                out_ready = lfsr[0];
            end
            BP_STALL: out_ready = 1'b0;
            default:  out_ready = 1'b1;
        endcase
    end

    // output monitor and scoreboard
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (out_empty) begin
                null_seen[out_chan]++;
            end else if (byte_q[out_chan].size() == 0) begin
                errors++;
                $display("unexpected data byte 0x%02h from channel %0d", out_data, out_chan);
            end else begin
                exp_byte = byte_q[out_chan].pop_front();
                check_value($sformatf("ch%0d data byte", out_chan), exp_byte, out_data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int errors_before;
        ctrl_wen   = 1'b0;
        ctrl_waddr = '0;
        ctrl_wdata = '0;
        ctrl_ren   = 1'b0;
        ctrl_raddr = '0;
        out_ready  = 1'b1;
        for (int c = 0; c < `PIO_NUM_CHANNELS; c++) begin
            keep_model[c] = '1;
            null_seen[c]  = 0;
            null_mark[c]  = 0;
        end
        build_table();
        cycle_limit = step_name.size() * 64 + 1000;

        @(posedge clk);
        wait (!rst);
        @(negedge clk);

        for (int i = 0; i < step_name.size(); i++) begin
            errors_before = errors;
            run_step(i);
            if (errors == errors_before) begin
                $display("step %0d %s: ok", i, step_name[i]);
            end else begin
                $display("step %0d %s: %0d error(s)", i, step_name[i], errors - errors_before);
            end
        end

        $display("steps %0d, checks %0d, errors %0d", step_name.size(), checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam time HALF_PERIOD = 2ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held over five rising edges and released on the next falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
